//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert
TOP       := fetch_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+source
source/fetch_pkg.sv
source/instruction_rom.sv
source/prefetch_queue.sv
source/predecode.sv
source/fetch_stage.sv
dv/fetch_chk.sv
dv/fetch_monitor.sv
dv/fetch_tb.sv

//--- dv/fetch_chk.sv
`timescale 1ns/10ps

`include "fetch_defs.svh"

module fetch_chk (
    input logic                                clock,
    input logic                                reset,
    input logic                                mem_busy,
    input logic                                fetch,
    input logic [$clog2(`PF_ENTRY_NUM+1)-1:0]  count,
    input logic [`XLEN-1:0]                    fetch_pc,
    input logic                                pending
);

    occupancy_bound: assert property (@(posedge clock) disable iff (reset)
        count <= `PF_ENTRY_NUM)
        else $error("queue occupancy above depth");

    // the ROM port belongs to the bus while busy, so nothing is appended
    no_fetch_when_busy: assert property (@(posedge clock) disable iff (reset)
        mem_busy |=> $stable(fetch_pc) && (count <= $past(count)))
        else $error("enqueue while mem_busy is high");

    pending_clears: assert property (@(posedge clock) disable iff (reset)
        (pending && fetch) |=> !pending)
        else $error("pending redirect kept after a fetch");

endmodule

bind prefetch_queue fetch_chk chk (
    .clock    (clock),
    .reset    (reset),
    .mem_busy (mem_busy),
    .fetch    (fetch),
    .count    (q.count),
    .fetch_pc (q.fetch_pc),
    .pending  (q.pending)
);

//--- dv/fetch_monitor.sv
`timescale 1ns/10ps

`include "fetch_defs.svh"

module fetch_monitor (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        en,
    input  logic                        take_branch,
    input  logic [`XLEN-1:0]            branch_target_pc,
    input  fetch_pkg::prefetch_packet_t packet,
    input  fetch_pkg::predecode_t       info,
    output int                          mismatch_count,
    output int                          failure_count,
    output int                          packet_count
);

    localparam int ROM_AW = $clog2(`ROM_WORDS);
    localparam int DEPTH  = `PF_ENTRY_NUM;

    logic [63:0]      image [0:`ROM_WORDS-1];
    int               mismatches = 0;
    int               failures = 0;
    int               packets = 0;
    logic             have_prev = 1'b0;
    logic [`XLEN-1:0] prev_pc = '0;
    // redirect targets not yet reached, oldest first
    logic [`XLEN-1:0] tgt_pc [$];
    int               tgt_age [$];
    logic             tgt_seen [$];

    assign mismatch_count = mismatches;
    assign failure_count  = failures;
    assign packet_count   = packets;

    initial begin
        $readmemh("program.hex", image);
    end

    function automatic logic [31:0] expected_inst(input logic [`XLEN-1:0] pc);
        logic [63:0] word;
        word = image[pc[ROM_AW+2:3]];
        return pc[2] ? word[63:32] : word[31:0];
    endfunction

    // reference decode straight from the base ISA bit positions
    function automatic fetch_pkg::predecode_t decode_ref(input logic [31:0] w);
        fetch_pkg::predecode_t d;
        d = '0;
        d.imm = {{20{w[31]}}, w[31:20]};
        if (w[6:0] == 7'b1100011) begin
            d.is_branch = 1'b1;
            d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end else if (w[6:0] == 7'b1101111) begin
            d.is_jal = 1'b1;
            d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end else if (w[6:0] == 7'b1100111) begin
            d.is_jalr = 1'b1;
        end
        return d;
    endfunction

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
        mismatches++;
    endtask

    task automatic failure(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        failures++;
    endtask

    task automatic check_packet();
        logic [`XLEN-1:0]      pc;
        logic [31:0]           exp_inst;
        fetch_pkg::predecode_t exp_info;
        logic                  sequential;
        int                    hit;
        pc = packet.pc;
        exp_inst = expected_inst(pc);
        exp_info = decode_ref(exp_inst);
        packets++;
        if (!have_prev && pc != `RESET_PC) begin
            mismatch("first packet_out.pc", `RESET_PC, pc);
        end
        if (packet.inst.raw != exp_inst) begin
            mismatch("packet_out.inst", exp_inst, packet.inst.raw);
        end
        if (packet.npc != pc + 32'd4) begin
            mismatch("packet_out.npc", pc + 32'd4, packet.npc);
        end
        if (info.is_branch != exp_info.is_branch) begin
            mismatch("predecode_out.is_branch", 32'(exp_info.is_branch), 32'(info.is_branch));
        end
        if (info.is_jal != exp_info.is_jal) begin
            mismatch("predecode_out.is_jal", 32'(exp_info.is_jal), 32'(info.is_jal));
        end
        if (info.is_jalr != exp_info.is_jalr) begin
            mismatch("predecode_out.is_jalr", 32'(exp_info.is_jalr), 32'(info.is_jalr));
        end
        if (info.imm != exp_info.imm) begin
            mismatch("predecode_out.imm", exp_info.imm, info.imm);
        end

        sequential = have_prev && (pc == prev_pc + 32'd4);
        hit = -1;
        for (int i = 0; i < tgt_pc.size(); i++) begin
            if (hit < 0 && tgt_pc[i] == pc) begin
                hit = i;
            end
        end
        if (have_prev && !sequential && hit < 0) begin
            mismatch("packet_out.pc", prev_pc + 32'd4, pc);
        end
        if (hit >= 0 && !sequential) begin
            // a jump to a target also retires every older one
            repeat (hit + 1) begin
                void'(tgt_pc.pop_front());
                void'(tgt_age.pop_front());
                void'(tgt_seen.pop_front());
            end
        end else if (hit >= 0) begin
            tgt_seen[hit] = 1'b1;
        end

        for (int i = 0; i < tgt_age.size(); i++) begin
            tgt_age[i]++;
        end
        if (tgt_pc.size() > 0 && !tgt_seen[$] && tgt_age[$] > DEPTH) begin
            failure($sformatf("redirect target %h not delivered within %0d packets",
                              tgt_pc[$], DEPTH + 1));
            tgt_seen[$] = 1'b1;
        end
        while (tgt_age.size() > 0 && tgt_age[0] > 2 * (DEPTH + 1)) begin
            void'(tgt_pc.pop_front());
            void'(tgt_age.pop_front());
            void'(tgt_seen.pop_front());
        end
        have_prev = 1'b1;
        prev_pc = pc;
    endtask

    // outputs are combinational, so mid-cycle is a stable point
    always @(negedge clock) begin
        if (reset) begin
            have_prev = 1'b0;
            tgt_pc.delete();
            tgt_age.delete();
            tgt_seen.delete();
        end else begin
            if (!en && packet.valid) begin
                failure("packet_out.valid high while en is low");
            end
            if (packet.valid) begin
                check_packet();
            end else if (packet != '0) begin
                failure("packet_out not all zero without a valid packet");
            end
            if (take_branch) begin
                tgt_pc.push_back(branch_target_pc);
                tgt_age.push_back(0);
                tgt_seen.push_back(1'b0);
            end
        end
    end

endmodule

//--- dv/fetch_tb.sv
`timescale 1ns/10ps

`include "fetch_defs.svh"

module fetch_tb;

    localparam logic [1:0] NEVER  = 2'd0;
    localparam logic [1:0] ALWAYS = 2'd1;
    localparam logic [1:0] RANDOM = 2'd2;
    localparam int PHASE_NUM = 10;

    typedef struct packed {
        logic [15:0] cycles;
        logic [1:0]  en_mode;
        logic [1:0]  busy_mode;
        logic        redirect;
        logic [31:0] target;
    } phase_t;

    logic                        clock;
    logic                        reset;
    logic                        en;
    logic                        mem_busy;
    logic                        take_branch;
    logic [`XLEN-1:0]            branch_target_pc;
    fetch_pkg::prefetch_packet_t packet_out;
    fetch_pkg::predecode_t       predecode_out;

    phase_t      phases [PHASE_NUM];
    logic [15:0] lfsr_state;
    int          cycle_count = 0;
    int          cycle_limit = 100;
    int          min_packets = 0;
    int          flow_errors = 0;
    int          mismatch_count;
    int          failure_count;
    int          packet_count;

    fetch_stage DUT (
        .clock            (clock),
        .reset            (reset),
        .en               (en),
        .mem_busy         (mem_busy),
        .take_branch      (take_branch),
        .branch_target_pc (branch_target_pc),
        .packet_out       (packet_out),
        .predecode_out    (predecode_out)
    );

    fetch_monitor monitor (
        .clock            (clock),
        .reset            (reset),
        .en               (en),
        .take_branch      (take_branch),
        .branch_target_pc (branch_target_pc),
        .packet           (packet_out),
        .info             (predecode_out),
        .mismatch_count   (mismatch_count),
        .failure_count    (failure_count),
        .packet_count     (packet_count)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic level_for(input logic [1:0] mode);
        if (mode == RANDOM) begin
            lfsr_state = lfsr_next(lfsr_state);
            return lfsr_state[0];
        end
        return mode == ALWAYS;
    endfunction

    task automatic load_phases();
        // fill under back-pressure, then drain
        phases[0] = '{16'd20, NEVER,  RANDOM, 1'b0, 32'h0000_0000};
        phases[1] = '{16'd30, ALWAYS, NEVER,  1'b0, 32'h0000_0000};
        phases[2] = '{16'd10, ALWAYS, NEVER,  1'b1, 32'h0000_0040};
        phases[3] = '{16'd20, RANDOM, RANDOM, 1'b0, 32'h0000_0000};
        // redirect while the bus holds the ROM port
        phases[4] = '{16'd6,  ALWAYS, ALWAYS, 1'b1, 32'h0000_0088};
        phases[5] = '{16'd20, ALWAYS, NEVER,  1'b0, 32'h0000_0000};
        // redirect while decode is stalled and the queue fills
        phases[6] = '{16'd10, NEVER,  NEVER,  1'b1, 32'h0000_00c4};
        phases[7] = '{16'd30, ALWAYS, RANDOM, 1'b0, 32'h0000_0000};
        phases[8] = '{16'd40, RANDOM, RANDOM, 1'b1, 32'h0000_001c};
        phases[9] = '{16'd40, ALWAYS, NEVER,  1'b0, 32'h0000_0000};
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        en = 1'b0;
        mem_busy = 1'b0;
        take_branch = 1'b0;
        branch_target_pc = '0;
        lfsr_state = 16'd59598;
        load_phases();
        for (int p = 0; p < PHASE_NUM; p++) begin
            cycle_limit += int'(phases[p].cycles);
            // decode pulling with the bus free takes one packet per cycle
            // once the first fetch of the phase has landed
            if (phases[p].en_mode == ALWAYS && phases[p].busy_mode == NEVER) begin
                min_packets += int'(phases[p].cycles) - 1;
            end
        end

        repeat (4) @(posedge clock);
        reset <= 1'b0;

        for (int p = 0; p < PHASE_NUM; p++) begin
            for (int c = 0; c < int'(phases[p].cycles); c++) begin
                @(posedge clock);
                en <= level_for(phases[p].en_mode);
                mem_busy <= level_for(phases[p].busy_mode);
                // one pulse halfway through the phase
                if (phases[p].redirect && c == int'(phases[p].cycles) / 2) begin
                    take_branch <= 1'b1;
                    branch_target_pc <= phases[p].target;
                end else begin
                    take_branch <= 1'b0;
                    branch_target_pc <= '0;
                end
            end
        end

        @(posedge clock);
        en <= 1'b0;
        mem_busy <= 1'b0;
        take_branch <= 1'b0;
        repeat (2) @(posedge clock);

        if (packet_count < min_packets) begin
            $display("ERROR t=%0t only %0d valid packets delivered, at least %0d expected",
                     $time, packet_count, min_packets);
            flow_errors = 1;
        end
        $display("checked %0d packets: %0d mismatches, %0d other errors",
                 packet_count, mismatch_count, failure_count + flow_errors);
        if (mismatch_count + failure_count + flow_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- program.hex
// one 64-bit word per line: instruction at pc+4 (upper half), instruction at pc (lower half)
// word n holds byte addresses 8n and 8n+4
002081b3_00100093
010000ef_fe208ce3
00311663_00008067
40118233_123452b7
ffc100e7_ff1ff06f
00100093_002081b3
fe208ce3_40118233
00008067_010000ef
123452b7_00311663
ff1ff06f_ffc100e7
002081b3_00100093
00311663_40118233
fe208ce3_123452b7
00008067_ffc100e7
010000ef_002081b3
ff1ff06f_00100093
40118233_00311663
123452b7_fe208ce3
ffc100e7_00008067
00100093_010000ef
002081b3_ff1ff06f
00311663_40118233
fe208ce3_00100093
010000ef_123452b7
00008067_002081b3
ffc100e7_00311663
ff1ff06f_fe208ce3
40118233_010000ef
00100093_00008067
123452b7_ffc100e7
002081b3_ff1ff06f
00311663_00100093

//--- source/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// address and instruction width
`define XLEN 32

// prefetch queue depth in instructions
`define PF_ENTRY_NUM 8

// instruction ROM size in 64-bit words
`define ROM_WORDS 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- source/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

    // one 32-bit instruction word, seen raw or through the base formats
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        // branch offset bits are scattered across the word
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_t;

    typedef struct packed {
        inst_t             inst;
        logic [`XLEN-1:0]  pc;
    } pf_entry_t;

    typedef struct packed {
        pf_entry_t [`PF_ENTRY_NUM-1:0]        entries;
        logic [$clog2(`PF_ENTRY_NUM+1)-1:0]  count;
        logic [`XLEN-1:0]                    fetch_pc;
        logic                                pending;
        logic [`XLEN-1:0]                    pending_pc;
    } pf_queue_t;

    typedef struct packed {
        logic              valid;
        inst_t             inst;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  npc;
    } prefetch_packet_t;

    typedef struct packed {
        logic              is_branch;
        logic              is_jal;
        logic              is_jalr;
        logic [`XLEN-1:0]  imm;
    } predecode_t;

endpackage

//--- source/fetch_stage.sv
`timescale 1ns/10ps

`include "fetch_defs.svh"

module fetch_stage (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        en,
    input  logic                        mem_busy,
    input  logic                        take_branch,
    input  logic [`XLEN-1:0]            branch_target_pc,
    output fetch_pkg::prefetch_packet_t packet_out,
    output fetch_pkg::predecode_t       predecode_out
);

    logic [`XLEN-1:0] rom_addr;
    logic [63:0]      rom_data;

    instruction_rom rom (
        .addr (rom_addr),
        .data (rom_data)
    );

    prefetch_queue queue (
        .clock            (clock),
        .reset            (reset),
        .en               (en),
        .mem_busy         (mem_busy),
        .take_branch      (take_branch),
        .branch_target_pc (branch_target_pc),
        .rom_data         (rom_data),
        .rom_addr         (rom_addr),
        .packet_out       (packet_out)
    );

    // classification follows the packet leaving the queue
    predecode decoder (
        .packet (packet_out),
        .info   (predecode_out)
    );

endmodule

//--- source/instruction_rom.sv
`timescale 1ns/10ps

`include "fetch_defs.svh"

module instruction_rom (
    input  logic [`XLEN-1:0] addr,
    output logic [63:0]      data
);

    // word index width, bits above it wrap around the ROM
    localparam int ROM_AW = $clog2(`ROM_WORDS);

    logic [63:0]       rom [0:`ROM_WORDS-1];
    logic [ROM_AW-1:0] word_index;

    // program image, two instructions per word, low half at the lower address
    initial begin
        $readmemh("program.hex", rom);
    end

    // byte address to 64-bit word index
    assign word_index = addr[ROM_AW+2:3];

    assign data = rom[word_index];

endmodule

//--- source/predecode.sv
`timescale 1ns/10ps

`include "fetch_defs.svh"

module predecode (
    input  fetch_pkg::prefetch_packet_t packet,
    output fetch_pkg::predecode_t       info
);

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    fetch_pkg::inst_t  inst;
    logic [6:0]        opcode;
    logic [`XLEN-1:0]  imm_i;
    logic [`XLEN-1:0]  imm_b;
    logic [`XLEN-1:0]  imm_j;

    assign inst   = packet.inst;
    assign opcode = inst.i.opcode;

    // bit 31 of the word is the sign bit in every view
    assign imm_i = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};

    assign imm_b = {{(`XLEN-12){inst.b.imm_12}},
                    inst.b.imm_11,
                    inst.b.imm_10_5,
                    inst.b.imm_4_1,
                    1'b0};

    assign imm_j = {{(`XLEN-20){inst.j.imm_20}},
                    inst.j.imm_19_12,
                    inst.j.imm_11,
                    inst.j.imm_10_1,
                    1'b0};

    always_comb begin
        info.is_branch = 1'b0;
        info.is_jal    = 1'b0;
        info.is_jalr   = 1'b0;
        info.imm       = imm_i;
        case (opcode)
            OP_BRANCH: begin
                info.is_branch = 1'b1;
                info.imm       = imm_b;
            end
            OP_JAL: begin
                info.is_jal = 1'b1;
                info.imm    = imm_j;
            end
            // jalr uses the plain I-type offset
            OP_JALR: begin
                info.is_jalr = 1'b1;
            end
            default: begin
                info.imm = imm_i;
            end
        endcase
    end

endmodule

//--- source/prefetch_queue.sv
`timescale 1ns/10ps

`include "fetch_defs.svh"

module prefetch_queue (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       en,
    input  logic                       mem_busy,
    input  logic                       take_branch,
    input  logic [`XLEN-1:0]           branch_target_pc,
    input  logic [63:0]                rom_data,
    output logic [`XLEN-1:0]           rom_addr,
    output fetch_pkg::prefetch_packet_t packet_out
);

    localparam int CNT_W = $clog2(`PF_ENTRY_NUM + 1);
    localparam int IDX_W = $clog2(`PF_ENTRY_NUM);

    fetch_pkg::pf_queue_t q;
    fetch_pkg::pf_queue_t q_next;

    logic               deq;
    logic               fetch;
    logic [CNT_W-1:0]   count_after_deq;
    logic [IDX_W-1:0]   tail_slot;
    fetch_pkg::inst_t   fetch_inst;

    // ROM is addressed by 64-bit word
    assign rom_addr = {q.fetch_pc[`XLEN-1:3], 3'b000};

    // PC bit 2 picks the upper instruction of the word
    assign fetch_inst = q.fetch_pc[2] ? rom_data[63:32] : rom_data[31:0];

    assign deq             = en && (q.count != '0);
    assign count_after_deq = q.count - CNT_W'(deq);
    assign fetch           = !mem_busy && (count_after_deq < CNT_W'(`PF_ENTRY_NUM));
    assign tail_slot       = count_after_deq[IDX_W-1:0];

    // head entry goes straight out in the same cycle
    always_comb begin
        if (deq) begin
            packet_out.valid = 1'b1;
            packet_out.inst  = q.entries[0].inst;
            packet_out.pc    = q.entries[0].pc;
            packet_out.npc   = q.entries[0].pc + `XLEN'(4);
        end else begin
            packet_out = '0;
        end
    end

    always_comb begin
        q_next = q;

        // pop: shift everything one slot toward the head
        if (deq) begin
            for (int i = 0; i < `PF_ENTRY_NUM - 1; i++) begin
                q_next.entries[i] = q.entries[i+1];
            end
            q_next.entries[`PF_ENTRY_NUM-1] = '0;
        end
        q_next.count = count_after_deq;

        if (fetch) begin
            q_next.entries[tail_slot].inst = fetch_inst;
            q_next.entries[tail_slot].pc   = q.fetch_pc;
            q_next.count                   = count_after_deq + CNT_W'(1);

            // a fresh redirect wins over an older pending one
            if (take_branch) begin
                q_next.fetch_pc = branch_target_pc;
                q_next.pending  = 1'b0;
            end else if (q.pending) begin
                q_next.fetch_pc = q.pending_pc;
                q_next.pending  = 1'b0;
            end else begin
                q_next.fetch_pc = q.fetch_pc + `XLEN'(4);
            end
        end else if (take_branch) begin
            // no fetch this cycle, keep the target until the next one
            q_next.pending    = 1'b1;
            q_next.pending_pc = branch_target_pc;
        end
    end

    always_ff @(posedge clock) begin
        q.entries    <= q_next.entries;
        q.pending_pc <= q_next.pending_pc;
        if (reset) begin
            q.count    <= '0;
            q.fetch_pc <= `RESET_PC;
            q.pending  <= 1'b0;
        end else begin
            q.count    <= q_next.count;
            q.fetch_pc <= q_next.fetch_pc;
            q.pending  <= q_next.pending;
        end
    end

endmodule
